/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int byte_w = 8;

  // opcode values of the first instruction byte
  localparam logic [byte_w-1:0] OP_HALT        = byte_w'(0);
  localparam logic [byte_w-1:0] OP_LOADFROMRAM = byte_w'(1);
  localparam logic [byte_w-1:0] OP_WRITETORAM  = byte_w'(3);
  localparam logic [byte_w-1:0] OP_ADD8        = byte_w'(4);
  localparam logic [byte_w-1:0] OP_ADDNUM8     = byte_w'(6);
  localparam logic [byte_w-1:0] OP_SET8        = byte_w'(9);

  // four fetched bytes, byte 0 in the top bits
  typedef union packed {
    // LOADFROMRAM and WRITETORAM
    struct packed {
      logic [byte_w-1:0] opcode;
      logic [byte_w-1:0] reg_start;
      logic [byte_w-1:0] length;
      logic [byte_w-1:0] ram_addr;
    } mv;
    // ADD8 / ADDNUM8 use src, dst, len; SET8 uses dst, len
    struct packed {
      logic [byte_w-1:0] opcode;
      logic [byte_w-1:0] op_a;
      logic [byte_w-1:0] op_b;
      logic [byte_w-1:0] op_c;
    } alu;
  } instr_u;

endpackage

`default_nettype wire

/* mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// byte access, req held until the one-cycle ready
interface mem_bus_if import cpu_pkg::*; #(
  parameter int RAM_ADDR_W = 10
) ();
  logic req;
  logic we;
  logic [RAM_ADDR_W-1:0] addr;
  logic [byte_w-1:0] wdata;
  logic [byte_w-1:0] rdata;
  logic ready;

  modport client (
    output req,
    output we,
    output addr,
    output wdata,
    input rdata,
    input ready
  );

  modport server (
    input req,
    input we,
    input addr,
    input wdata,
    output rdata,
    output ready
  );
endinterface

// instruction handoff from the sequencer to the two execution units
interface dispatch_if import cpu_pkg::*; ();
  logic start;
  instr_u instr;
  logic mov_busy;
  logic alu_busy;

  modport driver (
    output start,
    output instr,
    input mov_busy,
    input alu_busy
  );

  modport mov_unit (
    input start,
    input instr,
    output mov_busy
  );

  modport alu_unit (
    input start,
    input instr,
    output alu_busy
  );
endinterface

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram import cpu_pkg::*; #(
  parameter int RAM_ADDR_W = 10
) (
  input logic ram_clk,
  input logic stage3_read,
  mem_bus_if.server move_bus,
  mem_bus_if.server fetch_bus,
  mem_bus_if.server host_bus
);
  localparam int depth = 2 ** RAM_ADDR_W;

  logic [byte_w-1:0] mem [depth];
  logic [2:0] pick;
  logic [2:0] gnt;
  logic acc_we;
  logic [RAM_ADDR_W-1:0] acc_addr;
  logic [byte_w-1:0] acc_wdata;
  logic [byte_w-1:0] rd_q;

  // mover first, then fetch, then host; no grant in a ready cycle
  always_comb begin
    pick = 3'b000;
    if (gnt == 3'b000) begin
      if (move_bus.req) pick = 3'b001;
      else if (fetch_bus.req) pick = 3'b010;
      else if (host_bus.req) pick = 3'b100;
    end
  end

  always_comb begin
    acc_we = host_bus.we;
    acc_addr = host_bus.addr;
    acc_wdata = host_bus.wdata;
    if (pick[0]) begin
      acc_we = move_bus.we;
      acc_addr = move_bus.addr;
      acc_wdata = move_bus.wdata;
    end else if (pick[1]) begin
      acc_we = fetch_bus.we;
      acc_addr = fetch_bus.addr;
      acc_wdata = fetch_bus.wdata;
    end
  end

  always_ff @(posedge ram_clk) begin
    if (pick != 3'b000) begin
      if (acc_we) mem[acc_addr] <= acc_wdata;
      rd_q <= mem[acc_addr];
    end
  end

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      gnt <= 3'b000;
    end else begin
      gnt <= pick;
    end
  end

  assign move_bus.ready = gnt[0];
  assign fetch_bus.ready = gnt[1];
  assign host_bus.ready = gnt[2];
  assign move_bus.rdata = rd_q;
  assign fetch_bus.rdata = rd_q;
  assign host_bus.rdata = rd_q;

  one_ready: assert property (@(posedge ram_clk) disable iff (stage3_read)
    $onehot0({move_bus.ready, fetch_bus.ready, host_bus.ready}));

endmodule

`default_nettype wire

/* apb_host.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_host import cpu_pkg::*; #(
  parameter int RAM_ADDR_W = 10
) (
  input logic ram_clk,
  input logic stage3_read,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [11:0] paddr,
  input logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output logic start_run,
  input logic busy,
  input logic done,
  mem_bus_if.client host_bus
);
  localparam logic [11:0] ctrl_addr = 12'h400;
  localparam logic [11:0] status_addr = 12'h404;

  logic access;
  logic ram_hit;
  logic ctrl_hit;
  logic status_hit;
  logic done_q;

  assign access = psel && penable;
  // ram window is everything below CTRL
  assign ram_hit = paddr < ctrl_addr;
  assign ctrl_hit = paddr == ctrl_addr;
  assign status_hit = paddr == status_addr;

  assign host_bus.req = access && ram_hit;
  assign host_bus.we = pwrite;
  assign host_bus.addr = paddr[RAM_ADDR_W-1:0];
  assign host_bus.wdata = pwdata[byte_w-1:0];

  // ram accesses wait on the arbiter, registers answer at once
  assign pready = access && (ram_hit ? host_bus.ready : 1'b1);
  assign pslverr = access && !ram_hit && !ctrl_hit && !status_hit;
  assign start_run = access && pwrite && ctrl_hit && pwdata[0];

  always_comb begin
    prdata = '0;
    if (ram_hit) prdata = 32'(host_bus.rdata);
    else if (status_hit) prdata = {30'd0, done_q, busy};
  end

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      done_q <= 1'b0;
    end else if (start_run) begin
      done_q <= 1'b0;
    end else if (done) begin
      done_q <= 1'b1;
    end
  end

  ready_in_access: assert property (@(posedge ram_clk) disable iff (stage3_read)
    host_bus.ready |-> (psel && penable && ram_hit));

endmodule

`default_nettype wire

/* seq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl import cpu_pkg::*; #(
  parameter int RAM_ADDR_W = 10
) (
  input logic ram_clk,
  input logic stage3_read,
  input logic start_run,
  output logic busy,
  output logic halted,
  mem_bus_if.client fetch_bus,
  dispatch_if.driver dispatch
);
  logic running;
  logic [RAM_ADDR_W-1:0] pc;
  logic [1:0] byte_idx;
  // bytes 0..2; byte 3 goes straight into the slot
  logic [byte_w-1:0] fetch_buf [3];
  instr_u slot;
  logic slot_valid;
  logic units_idle;
  logic known_op;
  logic issue;

  assign units_idle = !dispatch.start && !dispatch.mov_busy && !dispatch.alu_busy;
  assign known_op = (slot.mv.opcode == OP_LOADFROMRAM) || (slot.mv.opcode == OP_WRITETORAM) ||
                    (slot.alu.opcode == OP_ADD8) || (slot.alu.opcode == OP_ADDNUM8) ||
                    (slot.alu.opcode == OP_SET8);
  assign issue = running && slot_valid && units_idle;

  // prefetch runs whenever the slot is free
  assign fetch_bus.req = running && !slot_valid;
  assign fetch_bus.we = 1'b0;
  assign fetch_bus.addr = pc;
  assign fetch_bus.wdata = '0;
  assign busy = running || halted;

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      running <= 1'b0;
      pc <= '0;
      byte_idx <= '0;
      slot_valid <= 1'b0;
      dispatch.start <= 1'b0;
      halted <= 1'b0;
    end else begin
      dispatch.start <= 1'b0;
      halted <= 1'b0;
      if (start_run) begin
        running <= 1'b1;
        pc <= '0;
        byte_idx <= '0;
        slot_valid <= 1'b0;
      end else if (running) begin
        if (fetch_bus.ready) begin
          pc <= pc + 1'b1;
          byte_idx <= byte_idx + 1'b1;
          if (byte_idx == 2'd3) slot_valid <= 1'b1;
        end
        if (issue) begin
          slot_valid <= 1'b0;
          if (known_op) begin
            dispatch.start <= 1'b1;
          end else begin
            // halt, or an opcode nobody takes
            running <= 1'b0;
            halted <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge ram_clk) begin
    if (fetch_bus.ready) begin
      if (byte_idx == 2'd3) begin
        slot <= {fetch_buf[0], fetch_buf[1], fetch_buf[2], fetch_bus.rdata};
      end else begin
        fetch_buf[byte_idx] <= fetch_bus.rdata;
      end
    end
    if (issue && known_op) dispatch.instr <= slot;
  end

  start_when_idle: assert property (@(posedge ram_clk) disable iff (stage3_read)
    dispatch.start |-> (!dispatch.mov_busy && !dispatch.alu_busy));

  start_taken: assert property (@(posedge ram_clk) disable iff (stage3_read)
    dispatch.start |=> (dispatch.mov_busy || dispatch.alu_busy));

endmodule

`default_nettype wire

/* mem_mover.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_mover import cpu_pkg::*; #(
  parameter int RAM_ADDR_W = 10,
  parameter int REG_ADDR_W = 6
) (
  input logic ram_clk,
  input logic stage3_read,
  dispatch_if.mov_unit dispatch,
  mem_bus_if.client move_bus,
  output logic [REG_ADDR_W-1:0] rd_addr,
  input logic [byte_w-1:0] rd_data,
  output logic wr_en,
  output logic [REG_ADDR_W-1:0] wr_addr,
  output logic [byte_w-1:0] wr_data
);
  logic take;
  logic busy_q;
  logic acc_q;
  logic is_load;
  logic [REG_ADDR_W-1:0] reg_base;
  logic [REG_ADDR_W-1:0] reg_ptr;
  logic [RAM_ADDR_W-1:0] ram_base;
  logic [byte_w-1:0] len;
  logic [byte_w-1:0] idx;

  assign take = dispatch.start && ((dispatch.instr.mv.opcode == OP_LOADFROMRAM) ||
                                   (dispatch.instr.mv.opcode == OP_WRITETORAM));
  assign reg_ptr = reg_base + REG_ADDR_W'(idx);
  assign rd_addr = reg_ptr;
  assign dispatch.mov_busy = busy_q;

  // store data comes straight from the register read port
  assign move_bus.req = busy_q && acc_q;
  assign move_bus.we = !is_load;
  assign move_bus.addr = ram_base + RAM_ADDR_W'(idx);
  assign move_bus.wdata = rd_data;

  // per byte: ram access until ready, then one write/step cycle
  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      busy_q <= 1'b0;
      acc_q <= 1'b0;
      wr_en <= 1'b0;
      idx <= '0;
    end else begin
      wr_en <= 1'b0;
      if (take) begin
        busy_q <= 1'b1;
        acc_q <= dispatch.instr.mv.length != '0;
        idx <= '0;
      end else if (busy_q && acc_q) begin
        if (move_bus.ready) begin
          acc_q <= 1'b0;
          wr_en <= is_load;
        end
      end else if (busy_q) begin
        if (idx + 1'b1 >= len) begin
          busy_q <= 1'b0;
        end else begin
          idx <= idx + 1'b1;
          acc_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge ram_clk) begin
    if (take) begin
      is_load <= dispatch.instr.mv.opcode == OP_LOADFROMRAM;
      reg_base <= REG_ADDR_W'(dispatch.instr.mv.reg_start);
      ram_base <= RAM_ADDR_W'(dispatch.instr.mv.ram_addr);
      len <= dispatch.instr.mv.length;
    end
    if (move_bus.ready) begin
      wr_addr <= reg_ptr;
      wr_data <= move_bus.rdata;
    end
  end

endmodule

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit import cpu_pkg::*; #(
  parameter int REG_ADDR_W = 6
) (
  input logic ram_clk,
  input logic stage3_read,
  dispatch_if.alu_unit dispatch,
  output logic [REG_ADDR_W-1:0] rd_addr,
  input logic [byte_w-1:0] rd_data,
  output logic wr_en,
  output logic [REG_ADDR_W-1:0] wr_addr,
  output logic [byte_w-1:0] wr_data
);
  logic take;
  logic is_set;
  logic busy_q;
  logic [byte_w-1:0] op_q;
  logic [byte_w-1:0] imm;
  logic [REG_ADDR_W-1:0] src;
  logic [REG_ADDR_W-1:0] dst;
  logic [byte_w-1:0] len;
  logic [byte_w-1:0] idx;

  assign is_set = dispatch.instr.alu.opcode == OP_SET8;
  assign take = dispatch.start && (is_set || (dispatch.instr.alu.opcode == OP_ADD8) ||
                                   (dispatch.instr.alu.opcode == OP_ADDNUM8));
  assign dispatch.alu_busy = busy_q;

  // read and write in the same cycle, so overlapping runs see earlier results
  assign rd_addr = src + REG_ADDR_W'(idx);
  assign wr_addr = dst + REG_ADDR_W'(idx);
  assign wr_en = busy_q && (idx < len);

  always_comb begin
    if (op_q == OP_SET8) wr_data = '0;
    else if (op_q == OP_ADDNUM8) wr_data = rd_data + imm;
    else wr_data = rd_data + rd_data;
  end

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      busy_q <= 1'b0;
      idx <= '0;
    end else if (take) begin
      busy_q <= 1'b1;
      idx <= '0;
    end else if (busy_q) begin
      // zero length still costs one cycle
      if (idx + 1'b1 >= len) busy_q <= 1'b0;
      else idx <= idx + 1'b1;
    end
  end

  // SET8 has dst and len one operand earlier
  always_ff @(posedge ram_clk) begin
    if (take) begin
      op_q <= dispatch.instr.alu.opcode;
      imm <= dispatch.instr.alu.op_a;
      src <= REG_ADDR_W'(dispatch.instr.alu.op_a);
      dst <= REG_ADDR_W'(is_set ? dispatch.instr.alu.op_a : dispatch.instr.alu.op_b);
      len <= is_set ? dispatch.instr.alu.op_b : dispatch.instr.alu.op_c;
    end
  end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; #(
  parameter int REG_ADDR_W = 6
) (
  input logic ram_clk,
  input logic stage3_read,
  input logic [REG_ADDR_W-1:0] mov_rd_addr,
  input logic [REG_ADDR_W-1:0] alu_rd_addr,
  input logic mov_wr_en,
  input logic [REG_ADDR_W-1:0] mov_wr_addr,
  input logic [byte_w-1:0] mov_wr_data,
  input logic alu_wr_en,
  input logic [REG_ADDR_W-1:0] alu_wr_addr,
  input logic [byte_w-1:0] alu_wr_data,
  output logic [byte_w-1:0] mov_rd_data,
  output logic [byte_w-1:0] alu_rd_data
);
  localparam int depth = 2 ** REG_ADDR_W;

  logic [byte_w-1:0] regs [depth];
  logic wr_en;
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [byte_w-1:0] wr_data;

  // one write source at a time
  assign wr_en = mov_wr_en || alu_wr_en;
  assign wr_addr = mov_wr_en ? mov_wr_addr : alu_wr_addr;
  assign wr_data = mov_wr_en ? mov_wr_data : alu_wr_data;

  always_ff @(posedge ram_clk or posedge stage3_read) begin
    if (stage3_read) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign mov_rd_data = regs[mov_rd_addr];
  assign alu_rd_data = regs[alu_rd_addr];

  single_writer: assert property (@(posedge ram_clk) disable iff (stage3_read)
    !(mov_wr_en && alu_wr_en));

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter int RAM_ADDR_W = 10,
  parameter int REG_ADDR_W = 6
) (
  input logic ram_clk,
  input logic stage3_read,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [11:0] paddr,
  input logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr
);
  logic start_run;
  logic core_busy;
  logic halted;
  logic [REG_ADDR_W-1:0] mov_rd_addr;
  logic [REG_ADDR_W-1:0] alu_rd_addr;
  logic [cpu_pkg::byte_w-1:0] mov_rd_data;
  logic [cpu_pkg::byte_w-1:0] alu_rd_data;
  logic mov_wr_en;
  logic alu_wr_en;
  logic [REG_ADDR_W-1:0] mov_wr_addr;
  logic [REG_ADDR_W-1:0] alu_wr_addr;
  logic [cpu_pkg::byte_w-1:0] mov_wr_data;
  logic [cpu_pkg::byte_w-1:0] alu_wr_data;

  mem_bus_if #(.RAM_ADDR_W(RAM_ADDR_W)) host_bus ();
  mem_bus_if #(.RAM_ADDR_W(RAM_ADDR_W)) fetch_bus ();
  mem_bus_if #(.RAM_ADDR_W(RAM_ADDR_W)) move_bus ();
  dispatch_if dispatch ();

  data_ram #(.RAM_ADDR_W(RAM_ADDR_W)) data_ram_inst (
    .ram_clk(ram_clk), .stage3_read(stage3_read),
    .move_bus(move_bus.server), .fetch_bus(fetch_bus.server), .host_bus(host_bus.server)
  );

  apb_host #(.RAM_ADDR_W(RAM_ADDR_W)) apb_host_inst (
    .ram_clk(ram_clk), .stage3_read(stage3_read),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .start_run(start_run),
    .busy(core_busy), .done(halted), .host_bus(host_bus.client)
  );

  seq_ctrl #(.RAM_ADDR_W(RAM_ADDR_W)) seq_ctrl_inst (
    .ram_clk(ram_clk), .stage3_read(stage3_read), .start_run(start_run),
    .busy(core_busy), .halted(halted),
    .fetch_bus(fetch_bus.client), .dispatch(dispatch.driver)
  );

  mem_mover #(.RAM_ADDR_W(RAM_ADDR_W), .REG_ADDR_W(REG_ADDR_W)) mem_mover_inst (
    .ram_clk(ram_clk), .stage3_read(stage3_read),
    .dispatch(dispatch.mov_unit), .move_bus(move_bus.client),
    .rd_addr(mov_rd_addr), .rd_data(mov_rd_data),
    .wr_en(mov_wr_en), .wr_addr(mov_wr_addr), .wr_data(mov_wr_data)
  );

  alu_unit #(.REG_ADDR_W(REG_ADDR_W)) alu_unit_inst (
    .ram_clk(ram_clk), .stage3_read(stage3_read), .dispatch(dispatch.alu_unit),
    .rd_addr(alu_rd_addr), .rd_data(alu_rd_data),
    .wr_en(alu_wr_en), .wr_addr(alu_wr_addr), .wr_data(alu_wr_data)
  );

  reg_file #(.REG_ADDR_W(REG_ADDR_W)) reg_file_inst (
    .ram_clk(ram_clk), .stage3_read(stage3_read),
    .mov_rd_addr(mov_rd_addr), .alu_rd_addr(alu_rd_addr),
    .mov_wr_en(mov_wr_en), .mov_wr_addr(mov_wr_addr), .mov_wr_data(mov_wr_data),
    .alu_wr_en(alu_wr_en), .alu_wr_addr(alu_wr_addr), .alu_wr_data(alu_wr_data),
    .mov_rd_data(mov_rd_data), .alu_rd_data(alu_rd_data)
  );

endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*;;
  localparam int num_progs = 24;
  localparam int max_instr = 13;
  localparam int instr_cycles = 400;
  localparam int apb_cycles = 8;
  localparam int apb_per_prog = 512;
  // ram fill phase, then every program with its final store and halt
  localparam int limit_cycles = (3 * 1024 + 16) * apb_cycles +
    (num_progs + 1) * ((max_instr + 6) * instr_cycles + apb_per_prog * apb_cycles);
  localparam logic [11:0] ctrl_addr = 12'h400;
  localparam logic [11:0] status_addr = 12'h404;
  localparam int data_base = 'h40;
  localparam int result_base = 'hc0;

  logic ram_clk;
  logic stage3_read;
  logic psel;
  logic penable;
  logic pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  logic [31:0] lcg_state = 32'hf145_d29b;
  logic [7:0] model_ram [1024];
  logic [7:0] model_regs [64];
  logic [31:0] prog [$];

  cpu_top #(.RAM_ADDR_W(10), .REG_ADDR_W(6)) cpu_top_inst (
    .ram_clk(ram_clk), .stage3_read(stage3_read),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #50 ram_clk = ~ram_clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[30:8]) % n;
  endfunction

  // register and ram indices wrap at the storage size
  function automatic logic [5:0] reg_at(logic [7:0] base, int i);
    return 6'(int'(base) + i);
  endfunction

  function automatic logic [9:0] ram_at(int base, int i);
    return 10'(base + i);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge ram_clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge ram_clk);
    penable <= 1'b1;
    // sample away from the rising edge
    @(negedge ram_clk);
    while (!pready) @(negedge ram_clk);
    rdata = prdata;
    err = pslverr;
    @(posedge ram_clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic ram_write(input int addr, input logic [7:0] data);
    logic [31:0] rd;
    logic err;
    model_ram[ram_at(addr, 0)] = data;
    apb_access(1'b1, 12'(addr), 32'(data), rd, err);
    check_value("pslverr", 32'(err), 32'd0);
  endtask

  task automatic ram_check(input int addr);
    logic [31:0] rd;
    logic err;
    apb_access(1'b0, 12'(addr), 32'd0, rd, err);
    check_value("pslverr", 32'(err), 32'd0);
    check_value($sformatf("prdata ram[0x%03h]", addr), rd, 32'(model_ram[ram_at(addr, 0)]));
  endtask

  function automatic logic [31:0] random_instr();
    logic [7:0] mem_at;
    mem_at = 8'(data_base + rand_below(128));
    case (rand_below(5))
      0: return {OP_LOADFROMRAM, 8'(rand_below(256)), 8'(rand_below(64)), mem_at};
      1: return {OP_WRITETORAM, 8'(rand_below(256)), 8'(rand_below(64)), mem_at};
      2: return {OP_ADD8, 8'(rand_below(256)), 8'(rand_below(256)), 8'(rand_below(71))};
      3: return {OP_ADDNUM8, 8'(rand_below(256)), 8'(rand_below(256)), 8'(rand_below(71))};
      default: return {OP_SET8, 8'(rand_below(256)), 8'(rand_below(71)), 8'(rand_below(256))};
    endcase
  endfunction

  // one element at a time, so overlapping runs see earlier results
  task automatic run_model();
    logic [7:0] op;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    foreach (prog[k]) begin
      {op, a, b, c} = prog[k];
      case (op)
        OP_LOADFROMRAM:
          for (int i = 0; i < int'(b); i++)
            model_regs[reg_at(a, i)] = model_ram[ram_at(int'(c), i)];
        OP_WRITETORAM:
          for (int i = 0; i < int'(b); i++)
            model_ram[ram_at(int'(c), i)] = model_regs[reg_at(a, i)];
        OP_ADD8:
          for (int i = 0; i < int'(c); i++)
            model_regs[reg_at(b, i)] = model_regs[reg_at(a, i)] + model_regs[reg_at(a, i)];
        OP_ADDNUM8:
          for (int i = 0; i < int'(c); i++)
            model_regs[reg_at(b, i)] = model_regs[reg_at(a, i)] + a;
        OP_SET8:
          for (int i = 0; i < int'(b); i++)
            model_regs[reg_at(a, i)] = 8'd0;
        default: ;
      endcase
    end
  endtask

  task automatic run_program();
    logic [31:0] rd;
    logic err;
    logic done;
    prog.push_back({OP_WRITETORAM, 8'd0, 8'd64, 8'(result_base)});
    prog.push_back(32'd0);
    foreach (prog[k]) begin
      for (int j = 0; j < 4; j++) ram_write(4 * k + j, 8'(prog[k] >> (24 - 8 * j)));
    end
    for (int a = data_base; a < 256; a++) ram_write(a, 8'(rand_below(256)));
    apb_access(1'b1, ctrl_addr, 32'd1, rd, err);
    check_value("pslverr", 32'(err), 32'd0);
    done = 1'b0;
    while (!done) begin
      apb_access(1'b0, status_addr, 32'd0, rd, err);
      done = rd[1];
      // host traffic outside program, data and result areas
      if (!done) ram_check(256 + rand_below(768));
    end
    check_value("status busy", 32'(rd[0]), 32'd0);
    run_model();
    for (int a = data_base; a < 256; a++) ram_check(a);
    prog.delete();
  endtask

  initial begin
    repeat (limit_cycles) @(posedge ram_clk);
    $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] rd;
    logic err;
    int n;
    ram_clk = 1'b0;
    stage3_read = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    model_ram = '{default: 8'd0};
    model_regs = '{default: 8'd0};
    repeat (10) @(posedge ram_clk);
    stage3_read <= 1'b0;

    for (int a = 0; a < 1024; a++) ram_write(a, 8'(next_rand() >> 24));
    for (int k = 0; k < 256; k++) ram_write(rand_below(1024), 8'(rand_below(256)));
    for (int a = 0; a < 1024; a++) ram_check(a);

    // unmapped writes whose low bits alias ram bytes, with data that differs from them
    apb_access(1'b1, 12'h408, {24'd0, ~model_ram['h008]}, rd, err);
    check_value("pslverr", 32'(err), 32'd1);
    apb_access(1'b1, 12'hffc, {24'd0, ~model_ram['h3fc]}, rd, err);
    check_value("pslverr", 32'(err), 32'd1);
    ram_check('h008);
    ram_check('h3fc);

    // register wrap and 8-bit overflow
    prog.push_back({OP_LOADFROMRAM, 8'd0, 8'd64, 8'(data_base)});
    prog.push_back({OP_SET8, 8'd60, 8'd8, 8'd0});
    prog.push_back({OP_ADD8, 8'd56, 8'd62, 8'd6});
    prog.push_back({OP_ADDNUM8, 8'hf5, 8'd30, 8'd20});
    prog.push_back({OP_ADDNUM8, 8'hc8, 8'd61, 8'd10});
    run_program();

    for (int p = 0; p < num_progs; p++) begin
      n = 1 + rand_below(max_instr);
      for (int k = 0; k < n; k++) prog.push_back(random_instr());
      run_program();
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
cpu_pkg.sv
mem_bus_if.sv
data_ram.sv
apb_host.sv
seq_ctrl.sv
mem_mover.sv
alu_unit.sv
reg_file.sv
cpu_top.sv
tb_cpu.sv

/* Makefile */
# Verilator build and run of the vector processor testbench

TOP := tb_cpu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
